/* design/fb_geom_pkg.sv */
`default_nettype none

package fb_geom_pkg;

	localparam int PIX_W = 8;			// bits per pixel
	localparam int PIX_PER_WORD = 4;	// pixels packed into one bus word

	localparam int H_PIX = 32;			// default active pixels per line
	localparam int V_LINES = 4;			// default lines per frame

	typedef logic [PIX_W-1:0] pix_t;
	typedef logic [7:0] line_t;			// line index inside a frame

endpackage

`default_nettype wire

/* design/fb_bus_pkg.sv */
`default_nettype none

package fb_bus_pkg;

	localparam int BUS_W = 32;		// bus word width
	localparam int ADDR_W = 10;		// word address width

	typedef logic [BUS_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// one read beat as kept in the reader FIFO
	typedef struct packed
	{
		logic	eol;	// final word of a line
		word_t	data;
	} rd_beat_t;

endpackage

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
#(
	parameter type payload_t = logic,
	parameter int DEPTH = 16
)
(
	input wire							r_mipi_pclk,
	input wire							r_i_arstn,
	input wire							i_push,
	input wire payload_t				i_data,
	input wire							i_pop,
	output payload_t					o_data,
	output logic						o_empty,
	output logic						o_full,
	output logic [$clog2(DEPTH+1)-1:0]	o_count
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t		r_mem [DEPTH];
	logic [AW-1:0]	r_wr_ptr;
	logic [AW-1:0]	r_rd_ptr;

	assign o_data = r_mem[r_rd_ptr];	// head word falls through
	assign o_empty = (o_count == '0);
	assign o_full = (o_count == DEPTH);

	always_ff @(posedge r_mipi_pclk)
	begin
		if (i_push)
			r_mem[r_wr_ptr] <= i_data;
	end

	always_ff @(posedge r_mipi_pclk or negedge r_i_arstn)
	begin
		if (!r_i_arstn)
		begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			o_count <= '0;
		end
		else
		begin
			if (i_push)
				r_wr_ptr <= (r_wr_ptr == AW'(DEPTH-1)) ? '0 : r_wr_ptr + 1'b1;
			if (i_pop)
				r_rd_ptr <= (r_rd_ptr == AW'(DEPTH-1)) ? '0 : r_rd_ptr + 1'b1;
			if (i_push && !i_pop)
				o_count <= o_count + 1'b1;
			else if (!i_push && i_pop)
				o_count <= o_count - 1'b1;
		end
	end

	// callers must respect the full and empty flags
	a_fifo_bounds: assert property (@(posedge r_mipi_pclk) disable iff (!r_i_arstn)
		!(i_push && o_full) && !(i_pop && o_empty));

endmodule

`default_nettype wire

/* design/line_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_packer
#(
	parameter int H_PIX = fb_geom_pkg::H_PIX,
	parameter int V_LINES = fb_geom_pkg::V_LINES
)
(
	input wire					r_mipi_pclk,
	input wire					r_i_arstn,
	input wire					i_vsync,
	input wire					i_de,
	input wire fb_geom_pkg::pix_t	i_pix,
	output logic				o_word_valid,
	output fb_bus_pkg::word_t	o_word,
	output fb_geom_pkg::line_t	o_word_line,
	output logic				o_word_eol
);

	localparam int XW = $clog2(H_PIX+1);
	localparam int PPW = fb_geom_pkg::PIX_PER_WORD;

	logic [XW-1:0]			r_x;		// pixel position in the line
	fb_geom_pkg::line_t		r_line;
	logic					r_vsync_d;
	logic					r_de_d;
	logic					w_take;
	logic					w_grp_end;

	// drop pixels past the line end and lines past the frame end
	assign w_take = i_de && (r_x < XW'(H_PIX)) && (r_line < V_LINES);
	assign w_grp_end = ((r_x % PPW) == PPW-1);

	always_ff @(posedge r_mipi_pclk)
	begin
		if (w_take)
		begin
			o_word <= {i_pix, o_word[fb_bus_pkg::BUS_W-1:fb_geom_pkg::PIX_W]};	// first pixel ends low
			o_word_line <= r_line;
		end
	end

	always_ff @(posedge r_mipi_pclk or negedge r_i_arstn)
	begin
		if (!r_i_arstn)
		begin
			r_x <= '0;
			r_line <= '0;
			r_vsync_d <= 1'b0;
			r_de_d <= 1'b0;
			o_word_valid <= 1'b0;
			o_word_eol <= 1'b0;
		end
		else
		begin
			r_vsync_d <= i_vsync;
			r_de_d <= i_de;
			o_word_valid <= w_take && w_grp_end;
			o_word_eol <= w_take && (r_x == XW'(H_PIX-1));
			if (!i_de)
				r_x <= '0;
			else if (r_x != XW'(H_PIX))
				r_x <= r_x + 1'b1;
			if (i_vsync && !r_vsync_d)
				r_line <= '0;					// frame start
			else if (r_de_d && !i_de && (r_line != '1))
				r_line <= r_line + 1'b1;		// de fell, line done
		end
	end

endmodule

`default_nettype wire

/* design/wr_burst_master.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_burst_master
#(
	parameter int H_PIX = fb_geom_pkg::H_PIX,
	parameter int V_LINES = fb_geom_pkg::V_LINES,
	parameter int FIFO_DEPTH = 16
)
(
	input wire						r_mipi_pclk,
	input wire						r_i_arstn,
	input wire						i_word_valid,
	input wire fb_bus_pkg::word_t	i_word,
	input wire fb_geom_pkg::line_t	i_word_line,
	input wire						i_word_eol,
	input wire						i_req_ready,
	input wire						i_w_ready,
	output logic					o_req_valid,
	output fb_bus_pkg::addr_t		o_req_addr,
	output logic					o_w_valid,
	output fb_bus_pkg::word_t		o_w_data,
	output logic					o_w_last,
	output logic					o_overflow
);

	localparam int WPL = H_PIX / fb_geom_pkg::PIX_PER_WORD;
	localparam int LQ_DEPTH = FIFO_DEPTH / WPL;		// complete lines that fit
	localparam int BW = (WPL > 1) ? $clog2(WPL) : 1;

	logic					w_push;
	logic					w_word_full;
	logic					w_word_empty;
	logic					w_line_empty;
	logic					w_beat;
	fb_geom_pkg::line_t		w_head_line;
	logic					r_busy;
	logic [BW-1:0]			r_beat;

	assign w_push = i_word_valid && !w_word_full;
	assign w_beat = o_w_valid && i_w_ready;

	sync_fifo #(.payload_t(fb_bus_pkg::word_t), .DEPTH(FIFO_DEPTH)) u_word_fifo
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_push			(w_push),
		.i_data			(i_word),
		.i_pop			(w_beat),
		.o_data			(o_w_data),
		.o_empty		(w_word_empty),
		.o_full			(w_word_full),
		.o_count		()
	);

	// one entry per complete line waiting in the word FIFO
	sync_fifo #(.payload_t(fb_geom_pkg::line_t), .DEPTH(LQ_DEPTH)) u_line_fifo
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_push			(w_push && i_word_eol),
		.i_data			(i_word_line),
		.i_pop			(w_beat && o_w_last),
		.o_data			(w_head_line),
		.o_empty		(w_line_empty),
		.o_full			(),
		.o_count		()
	);

	assign o_req_valid = !r_busy && !w_line_empty;
	assign o_req_addr = fb_bus_pkg::addr_t'(w_head_line * WPL);	// line base
	assign o_w_valid = r_busy && !w_word_empty;
	assign o_w_last = (r_beat == BW'(WPL-1));

	always_ff @(posedge r_mipi_pclk or negedge r_i_arstn)
	begin
		if (!r_i_arstn)
		begin
			r_busy <= 1'b0;
			r_beat <= '0;
			o_overflow <= 1'b0;
		end
		else
		begin
			if (o_req_valid && i_req_ready)
			begin
				r_busy <= 1'b1;
				r_beat <= '0;
			end
			else if (w_beat)
			begin
				r_beat <= r_beat + 1'b1;
				if (o_w_last)
					r_busy <= 1'b0;
			end
			if (i_word_valid && w_word_full)
				o_overflow <= 1'b1;		// sticky, word lost
		end
	end

	a_last_at_wpl: assert property (@(posedge r_mipi_pclk) disable iff (!r_i_arstn)
		(o_req_valid && i_req_ready) |-> ##1 w_beat [->WPL] ##0 o_w_last);

	// the packer never hands over a line outside the frame
	a_line_in_frame: assert property (@(posedge r_mipi_pclk) disable iff (!r_i_arstn)
		o_req_valid |-> (w_head_line < V_LINES));

endmodule

`default_nettype wire

/* design/rd_burst_master.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_burst_master
#(
	parameter int H_PIX = fb_geom_pkg::H_PIX,
	parameter int V_LINES = fb_geom_pkg::V_LINES,
	parameter int FIFO_DEPTH = 16
)
(
	input wire						r_mipi_pclk,
	input wire						r_i_arstn,
	input wire						i_rd_start,
	input wire						i_req_ready,
	input wire						i_r_valid,
	input wire fb_bus_pkg::word_t	i_r_data,
	input wire						i_r_last,
	input wire						i_pix_ready,
	output logic					o_req_valid,
	output fb_bus_pkg::addr_t		o_req_addr,
	output logic					o_r_ready,
	output logic					o_pix_valid,
	output fb_geom_pkg::pix_t		o_pix,
	output logic					o_eol,
	output logic					o_eof,
	output logic					o_rd_busy
);

	localparam int PPW = fb_geom_pkg::PIX_PER_WORD;
	localparam int WPL = H_PIX / PPW;
	localparam int CW = $clog2(FIFO_DEPTH+1);
	localparam int SW = (PPW > 1) ? $clog2(PPW) : 1;

	fb_bus_pkg::rd_beat_t	w_beat_in;
	fb_bus_pkg::rd_beat_t	w_head;
	logic					w_full;
	logic					w_empty;
	logic [CW-1:0]			w_count;
	logic					w_push;
	logic					w_pop;
	logic					w_pix_xfer;
	logic					w_room;
	logic					w_sub_end;
	logic					r_inflight;		// one burst outstanding
	fb_geom_pkg::line_t		r_req_line;
	fb_geom_pkg::line_t		r_out_line;
	logic [SW-1:0]			r_sub;			// pixel inside the head word

	assign w_beat_in = '{eol: i_r_last, data: i_r_data};
	assign o_r_ready = !w_full;
	assign w_push = i_r_valid && o_r_ready;

	sync_fifo #(.payload_t(fb_bus_pkg::rd_beat_t), .DEPTH(FIFO_DEPTH)) u_beat_fifo
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_push			(w_push),
		.i_data			(w_beat_in),
		.i_pop			(w_pop),
		.o_data			(w_head),
		.o_empty		(w_empty),
		.o_full			(w_full),
		.o_count		(w_count)
	);

	assign w_room = ((w_count + WPL) <= FIFO_DEPTH);	// a whole line still fits
	assign o_req_valid = o_rd_busy && !r_inflight && w_room && (r_req_line < V_LINES);
	assign o_req_addr = fb_bus_pkg::addr_t'(r_req_line * WPL);

	assign w_sub_end = (r_sub == SW'(PPW-1));
	assign o_pix_valid = !w_empty;
	assign o_pix = w_head.data[r_sub*fb_geom_pkg::PIX_W +: fb_geom_pkg::PIX_W];
	assign o_eol = w_head.eol && w_sub_end;
	assign o_eof = o_eol && (r_out_line == V_LINES-1);
	assign w_pix_xfer = o_pix_valid && i_pix_ready;
	assign w_pop = w_pix_xfer && w_sub_end;

	always_ff @(posedge r_mipi_pclk or negedge r_i_arstn)
	begin
		if (!r_i_arstn)
		begin
			o_rd_busy <= 1'b0;
			r_inflight <= 1'b0;
			r_req_line <= '0;
			r_out_line <= '0;
			r_sub <= '0;
		end
		else
		begin
			if (!o_rd_busy)
			begin
				if (i_rd_start)
				begin
					o_rd_busy <= 1'b1;
					r_req_line <= '0;
					r_out_line <= '0;
				end
			end
			else
			begin
				if (o_req_valid && i_req_ready)
				begin
					r_inflight <= 1'b1;
					r_req_line <= r_req_line + 1'b1;
				end
				if (w_push && i_r_last)
					r_inflight <= 1'b0;
				if (w_pix_xfer && o_eol)
					r_out_line <= r_out_line + 1'b1;
				if (w_pix_xfer && o_eof)
					o_rd_busy <= 1'b0;			// frame fully delivered
			end
			if (w_pix_xfer)
				r_sub <= w_sub_end ? '0 : r_sub + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
(
	input wire						r_mipi_pclk,
	input wire						r_i_arstn,
	input wire						i_wr_req_valid,
	output logic					o_wr_req_ready,
	input wire fb_bus_pkg::addr_t	i_wr_req_addr,
	input wire						i_wr_w_valid,
	output logic					o_wr_w_ready,
	input wire fb_bus_pkg::word_t	i_wr_w_data,
	input wire						i_wr_w_last,
	input wire						i_rd_req_valid,
	output logic					o_rd_req_ready,
	input wire fb_bus_pkg::addr_t	i_rd_req_addr,
	output logic					o_rd_r_valid,
	input wire						i_rd_r_ready,
	output fb_bus_pkg::word_t		o_rd_r_data,
	output logic					o_rd_r_last,
	output logic					o_mem_req_valid,
	input wire						i_mem_req_ready,
	output logic					o_mem_req_write,
	output fb_bus_pkg::addr_t		o_mem_req_addr,
	output logic					o_mem_w_valid,
	input wire						i_mem_w_ready,
	output fb_bus_pkg::word_t		o_mem_w_data,
	output logic					o_mem_w_last,
	input wire						i_mem_r_valid,
	output logic					o_mem_r_ready,
	input wire fb_bus_pkg::word_t	i_mem_r_data,
	input wire						i_mem_r_last
);

	logic	r_gnt_wr;
	logic	r_gnt_rd;
	logic	w_idle;
	logic	w_accept;

	assign w_idle = !r_gnt_wr && !r_gnt_rd;
	assign o_mem_req_valid = w_idle && (i_wr_req_valid || i_rd_req_valid);
	assign o_mem_req_write = i_wr_req_valid;		// pending write wins
	assign o_mem_req_addr = i_wr_req_valid ? i_wr_req_addr : i_rd_req_addr;
	assign o_wr_req_ready = w_idle && i_mem_req_ready;
	assign o_rd_req_ready = w_idle && i_mem_req_ready && !i_wr_req_valid;
	assign w_accept = o_mem_req_valid && i_mem_req_ready;

	assign o_mem_w_valid = r_gnt_wr && i_wr_w_valid;
	assign o_wr_w_ready = r_gnt_wr && i_mem_w_ready;
	assign o_mem_w_data = i_wr_w_data;
	assign o_mem_w_last = i_wr_w_last;
	assign o_rd_r_valid = r_gnt_rd && i_mem_r_valid;
	assign o_mem_r_ready = r_gnt_rd && i_rd_r_ready;
	assign o_rd_r_data = i_mem_r_data;
	assign o_rd_r_last = i_mem_r_last;

	always_ff @(posedge r_mipi_pclk or negedge r_i_arstn)
	begin
		if (!r_i_arstn)
		begin
			r_gnt_wr <= 1'b0;
			r_gnt_rd <= 1'b0;
		end
		else if (w_accept)
		begin
			r_gnt_wr <= i_wr_req_valid;
			r_gnt_rd <= !i_wr_req_valid;
		end
		else
		begin
			if (o_mem_w_valid && i_mem_w_ready && i_wr_w_last)
				r_gnt_wr <= 1'b0;		// write burst done
			if (o_rd_r_valid && i_rd_r_ready && i_mem_r_last)
				r_gnt_rd <= 1'b0;		// read burst done
		end
	end

	// a single grant, held only while the memory runs a burst
	a_one_grant: assert property (@(posedge r_mipi_pclk) disable iff (!r_i_arstn)
		!(r_gnt_wr && r_gnt_rd) && ((r_gnt_wr || r_gnt_rd) == !i_mem_req_ready));

endmodule

`default_nettype wire

/* design/frame_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_mem
#(
	parameter int H_PIX = fb_geom_pkg::H_PIX,
	parameter int V_LINES = fb_geom_pkg::V_LINES
)
(
	input wire						r_mipi_pclk,
	input wire						r_i_arstn,
	input wire						i_req_valid,
	input wire						i_req_write,
	input wire fb_bus_pkg::addr_t	i_req_addr,
	input wire						i_w_valid,
	input wire fb_bus_pkg::word_t	i_w_data,
	input wire						i_w_last,
	input wire						i_r_ready,
	output logic					o_req_ready,
	output logic					o_w_ready,
	output logic					o_r_valid,
	output fb_bus_pkg::word_t		o_r_data,
	output logic					o_r_last
);

	localparam int WPL = H_PIX / fb_geom_pkg::PIX_PER_WORD;
	localparam int WORDS = V_LINES * WPL;
	localparam int IW = (WORDS > 1) ? $clog2(WORDS) : 1;
	localparam int CW = $clog2(WPL+1);

	fb_bus_pkg::word_t		r_mem [WORDS];
	logic					r_active;
	logic					r_write;
	fb_bus_pkg::addr_t		r_addr;
	logic [CW-1:0]			r_cnt;		// read beats fetched
	logic					w_accept;
	logic					w_wbeat;
	logic					w_fetch;

	assign o_req_ready = !r_active;
	assign o_w_ready = r_active && r_write;
	assign w_accept = i_req_valid && o_req_ready;
	assign w_wbeat = o_w_ready && i_w_valid;
	// fetch the next word when the output register is free or draining
	assign w_fetch = r_active && !r_write && (r_cnt != CW'(WPL)) && (!o_r_valid || i_r_ready);

	always_ff @(posedge r_mipi_pclk)
	begin
		if (w_wbeat)
			r_mem[r_addr[IW-1:0]] <= i_w_data;
		if (w_fetch)
			o_r_data <= r_mem[r_addr[IW-1:0]];
		if (w_accept)
		begin
			r_addr <= i_req_addr;
			r_write <= i_req_write;
		end
		else if (w_wbeat || w_fetch)
			r_addr <= r_addr + 1'b1;
	end

	always_ff @(posedge r_mipi_pclk or negedge r_i_arstn)
	begin
		if (!r_i_arstn)
		begin
			r_active <= 1'b0;
			r_cnt <= '0;
			o_r_valid <= 1'b0;
			o_r_last <= 1'b0;
		end
		else
		begin
			if (w_accept)
			begin
				r_active <= 1'b1;
				r_cnt <= '0;
			end
			else if ((w_wbeat && i_w_last) || (o_r_valid && i_r_ready && o_r_last))
				r_active <= 1'b0;		// final beat moved
			if (w_fetch)
			begin
				o_r_valid <= 1'b1;
				o_r_last <= (r_cnt == CW'(WPL-1));
				r_cnt <= r_cnt + 1'b1;
			end
			else if (i_r_ready)
				o_r_valid <= 1'b0;
		end
	end

	// the arbiter only issues requests between bursts
	a_no_req_in_burst: assert property (@(posedge r_mipi_pclk) disable iff (!r_i_arstn)
		i_req_valid |-> !r_active);

endmodule

`default_nettype wire

/* design/frame_buf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buf_top
#(
	parameter int H_PIX = fb_geom_pkg::H_PIX,
	parameter int V_LINES = fb_geom_pkg::V_LINES,
	parameter int FIFO_DEPTH = 16
)
(
	input wire							r_mipi_pclk,
	input wire							r_i_arstn,
	input wire							i_vsync,
	input wire							i_de,
	input wire fb_geom_pkg::pix_t		i_pix,
	input wire							i_rd_start,
	output logic						o_rd_busy,
	output logic						o_pix_valid,
	input wire							i_pix_ready,
	output logic [fb_geom_pkg::PIX_W-1:0]	o_pix,
	output logic						o_eol,
	output logic						o_eof,
	output logic						o_overflow
);

	logic					w_word_valid;
	fb_bus_pkg::word_t		w_word;
	fb_geom_pkg::line_t		w_word_line;
	logic					w_word_eol;

	logic					w_wr_req_valid;
	logic					w_wr_req_ready;
	fb_bus_pkg::addr_t		w_wr_req_addr;
	logic					w_wr_w_valid;
	logic					w_wr_w_ready;
	fb_bus_pkg::word_t		w_wr_w_data;
	logic					w_wr_w_last;

	logic					w_rd_req_valid;
	logic					w_rd_req_ready;
	fb_bus_pkg::addr_t		w_rd_req_addr;
	logic					w_rd_r_valid;
	logic					w_rd_r_ready;
	fb_bus_pkg::word_t		w_rd_r_data;
	logic					w_rd_r_last;

	logic					w_mem_req_valid;
	logic					w_mem_req_ready;
	logic					w_mem_req_write;
	fb_bus_pkg::addr_t		w_mem_req_addr;
	logic					w_mem_w_valid;
	logic					w_mem_w_ready;
	fb_bus_pkg::word_t		w_mem_w_data;
	logic					w_mem_w_last;
	logic					w_mem_r_valid;
	logic					w_mem_r_ready;
	fb_bus_pkg::word_t		w_mem_r_data;
	logic					w_mem_r_last;

	line_packer #(.H_PIX(H_PIX), .V_LINES(V_LINES)) u_packer
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_vsync		(i_vsync),
		.i_de			(i_de),
		.i_pix			(i_pix),
		.o_word_valid	(w_word_valid),
		.o_word			(w_word),
		.o_word_line	(w_word_line),
		.o_word_eol		(w_word_eol)
	);

	wr_burst_master #(.H_PIX(H_PIX), .V_LINES(V_LINES), .FIFO_DEPTH(FIFO_DEPTH)) u_writer
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_word_valid	(w_word_valid),
		.i_word			(w_word),
		.i_word_line	(w_word_line),
		.i_word_eol		(w_word_eol),
		.i_req_ready	(w_wr_req_ready),
		.i_w_ready		(w_wr_w_ready),
		.o_req_valid	(w_wr_req_valid),
		.o_req_addr		(w_wr_req_addr),
		.o_w_valid		(w_wr_w_valid),
		.o_w_data		(w_wr_w_data),
		.o_w_last		(w_wr_w_last),
		.o_overflow		(o_overflow)
	);

	rd_burst_master #(.H_PIX(H_PIX), .V_LINES(V_LINES), .FIFO_DEPTH(FIFO_DEPTH)) u_reader
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_rd_start		(i_rd_start),
		.i_req_ready	(w_rd_req_ready),
		.i_r_valid		(w_rd_r_valid),
		.i_r_data		(w_rd_r_data),
		.i_r_last		(w_rd_r_last),
		.i_pix_ready	(i_pix_ready),
		.o_req_valid	(w_rd_req_valid),
		.o_req_addr		(w_rd_req_addr),
		.o_r_ready		(w_rd_r_ready),
		.o_pix_valid	(o_pix_valid),
		.o_pix			(o_pix),
		.o_eol			(o_eol),
		.o_eof			(o_eof),
		.o_rd_busy		(o_rd_busy)
	);

	bus_arbiter u_arbiter
	(
		.r_mipi_pclk		(r_mipi_pclk),
		.r_i_arstn			(r_i_arstn),
		.i_wr_req_valid		(w_wr_req_valid),
		.o_wr_req_ready		(w_wr_req_ready),
		.i_wr_req_addr		(w_wr_req_addr),
		.i_wr_w_valid		(w_wr_w_valid),
		.o_wr_w_ready		(w_wr_w_ready),
		.i_wr_w_data		(w_wr_w_data),
		.i_wr_w_last		(w_wr_w_last),
		.i_rd_req_valid		(w_rd_req_valid),
		.o_rd_req_ready		(w_rd_req_ready),
		.i_rd_req_addr		(w_rd_req_addr),
		.o_rd_r_valid		(w_rd_r_valid),
		.i_rd_r_ready		(w_rd_r_ready),
		.o_rd_r_data		(w_rd_r_data),
		.o_rd_r_last		(w_rd_r_last),
		.o_mem_req_valid	(w_mem_req_valid),
		.i_mem_req_ready	(w_mem_req_ready),
		.o_mem_req_write	(w_mem_req_write),
		.o_mem_req_addr		(w_mem_req_addr),
		.o_mem_w_valid		(w_mem_w_valid),
		.i_mem_w_ready		(w_mem_w_ready),
		.o_mem_w_data		(w_mem_w_data),
		.o_mem_w_last		(w_mem_w_last),
		.i_mem_r_valid		(w_mem_r_valid),
		.o_mem_r_ready		(w_mem_r_ready),
		.i_mem_r_data		(w_mem_r_data),
		.i_mem_r_last		(w_mem_r_last)
	);

	frame_mem #(.H_PIX(H_PIX), .V_LINES(V_LINES)) u_mem
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_req_valid	(w_mem_req_valid),
		.i_req_write	(w_mem_req_write),
		.i_req_addr		(w_mem_req_addr),
		.i_w_valid		(w_mem_w_valid),
		.i_w_data		(w_mem_w_data),
		.i_w_last		(w_mem_w_last),
		.i_r_ready		(w_mem_r_ready),
		.o_req_ready	(w_mem_req_ready),
		.o_w_ready		(w_mem_w_ready),
		.o_r_valid		(w_mem_r_valid),
		.o_r_data		(w_mem_r_data),
		.o_r_last		(w_mem_r_last)
	);

endmodule

`default_nettype wire

/* test/frame_buf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buf_tb;

	localparam int H_PIX = fb_geom_pkg::H_PIX;
	localparam int V_LINES = fb_geom_pkg::V_LINES;
	localparam int FIFO_DEPTH = 16;
	localparam int FRAME_PIX = H_PIX * V_LINES;
	localparam int DRV = 10;			// input drive delay after the rising edge
	localparam int LINE_GAP = 8;		// blanking cycles between lines
	localparam int IDLE = 16;			// idle cycles after each frame
	localparam int OVERLAP_DELAY = H_PIX + 8;
	localparam int N_TESTS = 6;

	typedef struct
	{
		string	name;
		int		frames;		// frames written before the read
		bit		lcg_pix;	// LCG pixels instead of incrementing ones
		int		bp_mode;	// 0 always ready, 1 LCG toggled ready
		int		extra;		// pixels sent past H_PIX in each line
		bit		overlap;	// last frame written while the read runs
	} test_row_t;

	test_row_t tests [N_TESTS] = '{
		'{"incr_frame",   1, 1'b0, 0, 0, 1'b0},
		'{"lcg_overwrite", 1, 1'b1, 0, 0, 1'b0},
		'{"backpressure", 1, 1'b1, 1, 0, 1'b0},
		'{"extra_pixels", 1, 1'b1, 0, 5, 1'b0},
		'{"two_frames_bp", 2, 1'b1, 1, 3, 1'b0},
		'{"read_in_write", 1, 1'b1, 0, 0, 1'b1}
	};

	logic					r_mipi_pclk;
	logic					r_i_arstn;
	logic					i_vsync;
	logic					i_de;
	fb_geom_pkg::pix_t		i_pix;
	logic					i_rd_start;
	logic					i_pix_ready;
	logic					o_rd_busy;
	logic					o_pix_valid;
	logic [fb_geom_pkg::PIX_W-1:0]	o_pix;
	logic					o_eol;
	logic					o_eof;
	logic					o_overflow;

	fb_geom_pkg::pix_t		model [FRAME_PIX];		// last pixel written per position
	fb_geom_pkg::pix_t		next_frame [FRAME_PIX];
	fb_geom_pkg::pix_t		got [FRAME_PIX];
	logic [31:0]			pix_seed;
	logic [31:0]			bp_seed;
	string					cur_test;
	int						n_errors;
	int						cycle_count;
	int						cycle_limit = 1000000;

	frame_buf_top #(.H_PIX(H_PIX), .V_LINES(V_LINES), .FIFO_DEPTH(FIFO_DEPTH)) dut0
	(
		.r_mipi_pclk	(r_mipi_pclk),
		.r_i_arstn		(r_i_arstn),
		.i_vsync		(i_vsync),
		.i_de			(i_de),
		.i_pix			(i_pix),
		.i_rd_start		(i_rd_start),
		.o_rd_busy		(o_rd_busy),
		.o_pix_valid	(o_pix_valid),
		.i_pix_ready	(i_pix_ready),
		.o_pix			(o_pix),
		.o_eol			(o_eol),
		.o_eof			(o_eof),
		.o_overflow		(o_overflow)
	);

	initial
	begin
		r_mipi_pclk = 1'b0;
		forever #50 r_mipi_pclk = ~r_mipi_pclk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// generous bound from the write and read lengths of every row
	function automatic int calc_limit();
		int total;
		total = 20;
		foreach (tests[i])
			total += tests[i].frames * (2 + V_LINES * (H_PIX + tests[i].extra + LINE_GAP) + IDLE)
				+ 8 * FRAME_PIX + 20;
		return 2 * total;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_val(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val)
		begin
			n_errors++;
			stop_on_error($sformatf("mismatch %s %s: expected %0h, actual %0h",
				cur_test, what, exp_val, act_val));
		end
	endtask

	always @(posedge r_mipi_pclk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
			stop_on_error($sformatf("timeout: the run did not finish in %0d cycles",
				cycle_limit));
	end

	task automatic gen_frame(input bit use_lcg);
		for (int i = 0; i < FRAME_PIX; i++)
		begin
			if (use_lcg)
			begin
				pix_seed = lcg_step(pix_seed);
				next_frame[i] = pix_seed[23:16];
			end
			else
				next_frame[i] = fb_geom_pkg::pix_t'(i);		// incrementing
		end
	endtask

	// starts and ends a small delay after a rising edge
	task automatic send_frame(input int extra);
		i_vsync = 1'b1;
		@(posedge r_mipi_pclk);
		#DRV;
		i_vsync = 1'b0;
		for (int l = 0; l < V_LINES; l++)
		begin
			for (int x = 0; x < H_PIX + extra; x++)
			begin
				i_de = 1'b1;
				if (x < H_PIX)
					i_pix = next_frame[l * H_PIX + x];
				else
				begin
					pix_seed = lcg_step(pix_seed);
					i_pix = pix_seed[23:16];		// must be dropped
				end
				@(posedge r_mipi_pclk);
				#DRV;
			end
			i_de = 1'b0;
			i_pix = '0;
			repeat (LINE_GAP) @(posedge r_mipi_pclk);
			#DRV;
		end
		repeat (IDLE) @(posedge r_mipi_pclk);
		#DRV;
	endtask

	task automatic read_frame(input int bp_mode);
		int n;
		n = 0;
		i_rd_start = 1'b1;
		@(posedge r_mipi_pclk);
		#DRV;
		i_rd_start = 1'b0;
		i_pix_ready = 1'b1;
		@(negedge r_mipi_pclk);
		check_val("rd_busy after start", 1, o_rd_busy);
		while (n < FRAME_PIX)
		begin
			if (o_pix_valid && i_pix_ready)		// transfers at the next edge
			begin
				got[n] = o_pix;
				check_val($sformatf("eol at pixel %0d", n), (n % H_PIX) == H_PIX - 1, o_eol);
				check_val($sformatf("eof at pixel %0d", n), n == FRAME_PIX - 1, o_eof);
				n++;
			end
			@(posedge r_mipi_pclk);
			#DRV;
			if (bp_mode == 1)
			begin
				bp_seed = lcg_step(bp_seed);
				i_pix_ready = bp_seed[16];
			end
			@(negedge r_mipi_pclk);
		end
		check_val("rd_busy after eof", 0, o_rd_busy);
		check_val("pix_valid after eof", 0, o_pix_valid);	// nothing repeated
		@(posedge r_mipi_pclk);
		#DRV;
		i_pix_ready = 1'b1;
	endtask

	task automatic check_readback(input bit overlap);
		bit same_old;
		bit same_new;
		for (int l = 0; l < V_LINES; l++)
		begin
			if (overlap)
			begin
				same_old = 1'b1;
				same_new = 1'b1;
				for (int x = 0; x < H_PIX; x++)
				begin
					if (got[l * H_PIX + x] !== model[l * H_PIX + x])
						same_old = 1'b0;
					if (got[l * H_PIX + x] !== next_frame[l * H_PIX + x])
						same_new = 1'b0;
				end
				check_val($sformatf("line %0d old or new", l), 1, same_old || same_new);
			end
			else
				for (int x = 0; x < H_PIX; x++)
					check_val($sformatf("pixel %0d,%0d", l, x), model[l * H_PIX + x],
						got[l * H_PIX + x]);
		end
	endtask

	initial
	begin
		r_i_arstn = 1'b0;
		i_vsync = 1'b0;
		i_de = 1'b0;
		i_pix = '0;
		i_rd_start = 1'b0;
		i_pix_ready = 1'b1;
		pix_seed = 32'h1202_aee4;
		bp_seed = lcg_step(32'h1202_aee4);
		n_errors = 0;
		cycle_count = 0;
		cycle_limit = calc_limit();
		cur_test = "reset";
		repeat (5) @(posedge r_mipi_pclk);
		#DRV;
		r_i_arstn = 1'b1;
		@(negedge r_mipi_pclk);
		check_val("pix_valid", 0, o_pix_valid);
		check_val("rd_busy", 0, o_rd_busy);
		check_val("overflow", 0, o_overflow);
		@(posedge r_mipi_pclk);
		#DRV;

		foreach (tests[t])
		begin
			cur_test = tests[t].name;
			for (int f = 0; f < tests[t].frames; f++)
			begin
				gen_frame(tests[t].lcg_pix);
				if (tests[t].overlap && (f == tests[t].frames - 1))
				begin
					fork
						send_frame(tests[t].extra);
						begin
							repeat (OVERLAP_DELAY) @(posedge r_mipi_pclk);
							#DRV;
							read_frame(tests[t].bp_mode);
						end
					join
					check_readback(1'b1);
				end
				else
					send_frame(tests[t].extra);
				model = next_frame;
			end
			if (!tests[t].overlap)
			begin
				read_frame(tests[t].bp_mode);
				check_readback(1'b0);
			end
			check_val("overflow", 0, o_overflow);
			check_val("rd_busy at end", 0, o_rd_busy);
		end

		if (n_errors == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
			stop_on_error($sformatf("%0d checks failed", n_errors));
	end

endmodule

`default_nettype wire

/* src.f */
design/fb_geom_pkg.sv
design/fb_bus_pkg.sv
design/sync_fifo.sv
design/line_packer.sv
design/wr_burst_master.sv
design/rd_burst_master.sv
design/bus_arbiter.sv
design/frame_mem.sv
design/frame_buf_top.sv
test/frame_buf_tb.sv

/* Bender.yml */
package:
  name: frame_buf

sources:
  - design/fb_geom_pkg.sv
  - design/fb_bus_pkg.sv
  - design/sync_fifo.sv
  - design/line_packer.sv
  - design/wr_burst_master.sv
  - design/rd_burst_master.sv
  - design/bus_arbiter.sv
  - design/frame_mem.sv
  - design/frame_buf_top.sv
  - target: test
    files:
      - test/frame_buf_tb.sv
